// ==== hdl/lsu_pkg.sv ====
// load/store unit package
// widths, vector types, size and FSM encodings and the request structs
// shared by the control FSM and the two alignment datapaths
`default_nettype none

package lsu_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  localparam int unsigned XLEN      = 32;        // data and address width
  localparam int unsigned NUM_LANES = XLEN / 8;  // byte lanes per word

  typedef logic [XLEN-1:0]                  addr_t;   // byte address
  typedef logic [XLEN-1:0]                  data_t;   // data word
  typedef logic [NUM_LANES-1:0]             be_t;     // byte enables
  typedef logic [$clog2(NUM_LANES)-1:0]     offset_t; // byte inside a word

  //////////////////////////////
  // encodings
  //////////////////////////////

  // two byte codes, as the decoder hands them over
  typedef enum logic [1:0] {
    LSU_WORD     = 2'b00,
    LSU_HALF     = 2'b01,
    LSU_BYTE     = 2'b10,
    LSU_BYTE_ALT = 2'b11
  } lsu_size_e;

  typedef enum logic [2:0] {
    LS_IDLE,
    LS_WAIT_GNT_MIS,               // first part of a split access not yet granted
    LS_WAIT_RVALID_MIS,            // first part granted, second part on the bus
    LS_WAIT_GNT,                   // last part waits for grant
    LS_WAIT_RVALID_MIS_GNTS_DONE   // both granted, first response outstanding
  } ls_state_e;

  //////////////////////////////
  // request structs
  //////////////////////////////

  typedef struct packed {
    logic      we;
    lsu_size_e size;
    logic      sign_ext;
    addr_t     addr;               // byte address from the ALU
    data_t     wdata;              // store value, byte 0 in bits 7:0
  } lsu_req_t;

  typedef struct packed {
    addr_t addr;                   // always word aligned
    logic  we;
    be_t   be;
    data_t wdata;                  // lane-rotated store data
  } bus_req_t;

  typedef struct packed {
    offset_t   offset;
    lsu_size_e size;
    logic      sign_ext;
  } ld_ctrl_t;

endpackage

`default_nettype wire

// ==== hdl/lsu_ctrl.sv ====
// load/store unit control
// decides whether an access splits into two word transactions, walks the
// grant/response sequence, carries the first-part error to the final
// response and keeps the last address for the trap value
`default_nettype none

module lsu_ctrl import lsu_pkg::*; (
  input  wire           clk_i,
  input  wire           rst_ni,
  input  wire           lsu_req_i,
  input  wire lsu_req_t lsu_acc_i,
  input  wire           data_gnt_i,
  input  wire           data_rvalid_i,
  input  wire           data_err_i,
  output logic          data_req_o,
  output logic          addr_incr_req_o,   // core drives addr + 4 while high
  output logic          second_part_o,
  output logic          ctrl_update_o,     // load format capture, every grant
  output ld_ctrl_t      ld_ctrl_o,
  output logic          rdata_update_o,    // first part of split load is back
  output logic          lsu_req_done_o,
  output logic          lsu_resp_valid_o,
  output logic          lsu_rdata_valid_o,
  output logic          load_err_o,
  output logic          store_err_o,
  output addr_t         addr_last_o,
  output logic          busy_o
);

  ls_state_e state_q, state_d;
  logic      second_q, second_d;          // second part is the one on the bus
  logic      err_q, err_d;                // error seen on the first part
  logic      we_q;                        // direction of the access in flight
  addr_t     addr_last_q, addr_last_d;
  addr_t     addr_next_w;                 // word address of the second part
  offset_t   offset;
  logic      split_access;
  logic      last_part;                   // a grant now ends the request phase
  logic      addr_update;
  logic      addr_second;                 // record the second-part address
  logic      final_err;

  assign offset = lsu_acc_i.addr[$clog2(NUM_LANES)-1:0];

  // misaligned word, or a halfword that runs into the next word
  assign split_access = ((lsu_acc_i.size == LSU_WORD) && (offset != '0)) ||
                        ((lsu_acc_i.size == LSU_HALF) && (offset == '1));

  // first address is always recorded at the first grant, so this holds
  // even after the core has let go of the request
  assign addr_next_w = {addr_last_q[XLEN-1:2] + 1'b1, 2'b00};

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_comb begin
    state_d         = state_q;
    second_d        = second_q;
    err_d           = err_q;
    data_req_o      = 1'b0;
    addr_incr_req_o = 1'b0;
    rdata_update_o  = 1'b0;
    addr_update     = 1'b0;
    addr_second     = 1'b0;
    last_part       = 1'b0;

    unique case (state_q)
      LS_IDLE: begin
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          err_d      = 1'b0;               // fresh access
          last_part  = ~split_access;
          if (data_gnt_i) begin
            addr_update = 1'b1;
            second_d    = split_access;
            state_d     = split_access ? LS_WAIT_RVALID_MIS : LS_IDLE;
          end else begin
            state_d     = split_access ? LS_WAIT_GNT_MIS : LS_WAIT_GNT;
          end
        end
      end

      LS_WAIT_GNT_MIS: begin
        data_req_o = 1'b1;                 // back-pressure on the first part
        if (data_gnt_i) begin
          addr_update = 1'b1;
          second_d    = 1'b1;
          state_d     = LS_WAIT_RVALID_MIS;
        end
      end

      LS_WAIT_RVALID_MIS: begin
        // second request goes out before the first response is back
        data_req_o      = 1'b1;
        addr_incr_req_o = 1'b1;
        last_part       = 1'b1;
        if (data_rvalid_i) begin
          err_d          = data_err_i;
          rdata_update_o = ~we_q;
          addr_update    = data_gnt_i & ~data_err_i;  // keep first failing addr
          addr_second    = 1'b1;
          second_d       = ~data_gnt_i;
          state_d        = data_gnt_i ? LS_IDLE : LS_WAIT_GNT;
        end else if (data_gnt_i) begin
          second_d = 1'b0;
          state_d  = LS_WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      LS_WAIT_GNT: begin
        data_req_o      = 1'b1;
        addr_incr_req_o = second_q;        // only for the tail of a split
        last_part       = 1'b1;
        if (data_gnt_i) begin
          addr_update = ~err_q;
          addr_second = second_q;
          second_d    = 1'b0;
          state_d     = LS_IDLE;
        end
      end

      LS_WAIT_RVALID_MIS_GNTS_DONE: begin
        // both parts granted, first response still to come
        if (data_rvalid_i) begin
          err_d          = data_err_i;
          rdata_update_o = ~we_q;
          addr_update    = ~data_err_i;
          addr_second    = 1'b1;
          state_d        = LS_IDLE;        // second response ends the access
        end
      end

      default: begin
        state_d = LS_IDLE;
      end
    endcase
  end

  assign addr_last_d = addr_second ? addr_next_w : lsu_acc_i.addr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= LS_IDLE;
      second_q    <= 1'b0;
      err_q       <= 1'b0;
      we_q        <= 1'b0;
      addr_last_q <= '0;
    end else begin
      state_q  <= state_d;
      second_q <= second_d;
      err_q    <= err_d;
      if (ctrl_update_o) begin
        we_q <= lsu_acc_i.we;
      end
      if (addr_update) begin
        addr_last_q <= addr_last_d;
      end
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////

  assign second_part_o = second_q;
  assign ctrl_update_o = data_req_o & data_gnt_i;
  assign ld_ctrl_o     = '{offset: offset, size: lsu_acc_i.size,
                           sign_ext: lsu_acc_i.sign_ext};

  assign lsu_req_done_o = data_req_o & data_gnt_i & last_part;

  // a response in idle is always the last one of its access
  assign lsu_resp_valid_o  = data_rvalid_i & (state_q == LS_IDLE);
  assign final_err         = err_q | data_err_i;
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~final_err & ~we_q;
  assign load_err_o        = lsu_resp_valid_o & final_err & ~we_q;
  assign store_err_o       = lsu_resp_valid_o & final_err & we_q;

  assign addr_last_o = addr_last_q;
  assign busy_o      = (state_q != LS_IDLE);

endmodule

`default_nettype wire

// ==== hdl/lsu_wdata_align.sv ====
// store-side alignment
// word address, byte enables for each size, offset and part,
// and rotation of store data into lane position
`default_nettype none

module lsu_wdata_align import lsu_pkg::*; (
  input  wire lsu_req_t lsu_acc_i,
  input  wire           second_part_i,
  output bus_req_t      bus_req_o
);

  offset_t offset;
  be_t     be;
  data_t   wdata_rot;

  assign offset = lsu_acc_i.addr[$clog2(NUM_LANES)-1:0];

  //////////////////////////////
  // byte enables
  //////////////////////////////

  always_comb begin
    unique case (lsu_acc_i.size)
      LSU_WORD: begin
        if (!second_part_i) be = {NUM_LANES{1'b1}} << offset;   // offset and up
        else                be = ~({NUM_LANES{1'b1}} << offset); // below offset
      end
      LSU_HALF: begin
        if (!second_part_i) be = be_t'(4'b0011) << offset;  // top lane only at 3
        else                be = be_t'(4'b0001);            // spill into lane 0
      end
      LSU_BYTE, LSU_BYTE_ALT: be = be_t'(4'b0001) << offset;
      default:                be = {NUM_LANES{1'b1}};
    endcase
  end

  //////////////////////////////
  // lane rotation
  //////////////////////////////

  // byte 0 lands in lane offset, the upper bytes wrap round into
  // the low lanes for the second part of a split store
  always_comb begin
    unique case (offset)
      2'd1:    wdata_rot = {lsu_acc_i.wdata[23:0], lsu_acc_i.wdata[31:24]};
      2'd2:    wdata_rot = {lsu_acc_i.wdata[15:0], lsu_acc_i.wdata[31:16]};
      2'd3:    wdata_rot = {lsu_acc_i.wdata[7:0],  lsu_acc_i.wdata[31:8]};
      default: wdata_rot = lsu_acc_i.wdata;
    endcase
  end

  assign bus_req_o.addr  = {lsu_acc_i.addr[XLEN-1:2], 2'b00};  // word aligned
  assign bus_req_o.we    = lsu_acc_i.we;
  assign bus_req_o.be    = be;
  assign bus_req_o.wdata = wdata_rot;

endmodule

`default_nettype wire

// ==== hdl/lsu_rdata_align.sv ====
// load-side alignment
// holds the upper bytes of the first part of a split load, joins them
// with the second response and extends the selected word, halfword or byte
`default_nettype none

module lsu_rdata_align import lsu_pkg::*; (
  input  wire           clk_i,
  input  wire           rst_ni,
  input  wire           ctrl_update_i,   // grant cycle, capture load format
  input  wire ld_ctrl_t ld_ctrl_i,
  input  wire           rdata_update_i,  // first part of a split load is back
  input  wire data_t    data_rdata_i,
  output data_t         lsu_rdata_o
);

  ld_ctrl_t        ld_ctrl_q;   // format of the load in flight
  logic [XLEN-1:8] rdata_q;     // lanes 1..3 of the first part
  data_t           rdata_w;     // word realigned across both parts
  data_t           rdata_sh;    // response shifted down to the offset
  logic [15:0]     rdata_h;
  logic [7:0]      rdata_b;

  //////////////////////////////
  // capture registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ld_ctrl_q <= '0;
    end else if (ctrl_update_i) begin
      ld_ctrl_q <= ld_ctrl_i;     // same offset for both parts
    end
  end

  // lane 0 of the first part is never part of a split load
  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= data_rdata_i[XLEN-1:8];
    end
  end

  //////////////////////////////
  // realignment
  //////////////////////////////

  // misaligned word, low bytes from the first part
  always_comb begin
    unique case (ld_ctrl_q.offset)
      2'd1:    rdata_w = {data_rdata_i[7:0],  rdata_q[31:8]};
      2'd2:    rdata_w = {data_rdata_i[15:0], rdata_q[31:16]};
      2'd3:    rdata_w = {data_rdata_i[23:0], rdata_q[31:24]};
      default: rdata_w = data_rdata_i;
    endcase
  end

  assign rdata_sh = data_rdata_i >> {ld_ctrl_q.offset, 3'b000};

  // halfword at offset 3 is the only one that spans two words
  assign rdata_h = (ld_ctrl_q.offset == 2'd3) ? rdata_w[15:0] : rdata_sh[15:0];
  assign rdata_b = rdata_sh[7:0];

  //////////////////////////////
  // extension
  //////////////////////////////

  always_comb begin
    unique case (ld_ctrl_q.size)
      LSU_WORD: begin
        lsu_rdata_o = rdata_w;
      end
      LSU_HALF: begin
        lsu_rdata_o = {{(XLEN-16){ld_ctrl_q.sign_ext & rdata_h[15]}}, rdata_h};
      end
      LSU_BYTE, LSU_BYTE_ALT: begin
        lsu_rdata_o = {{(XLEN-8){ld_ctrl_q.sign_ext & rdata_b[7]}}, rdata_b};
      end
      default: begin
        lsu_rdata_o = rdata_w;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/lsu_top.sv ====
// load/store unit top level
// joins the control FSM with the store and load alignment paths
// between the core execute stage and the data bus
`default_nettype none

module lsu_top import lsu_pkg::*; (
  input  wire           clk_i,
  input  wire           rst_ni,
  // core side
  input  wire           lsu_req_i,
  input  wire lsu_req_t lsu_acc_i,
  output logic          lsu_req_done_o,
  output logic          lsu_resp_valid_o,
  output logic          lsu_rdata_valid_o,
  output data_t         lsu_rdata_o,
  output logic          addr_incr_req_o,
  output addr_t         addr_last_o,      // trap value
  output logic          load_err_o,
  output logic          store_err_o,
  output logic          busy_o,
  // data bus
  output logic          data_req_o,
  output bus_req_t      data_req_fields_o,
  input  wire           data_gnt_i,
  input  wire           data_rvalid_i,
  input  wire           data_err_i,
  input  wire data_t    data_rdata_i
);

  logic     second_part;
  logic     ctrl_update;
  ld_ctrl_t ld_ctrl;
  logic     rdata_update;

  lsu_ctrl u_lsu_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .lsu_acc_i         (lsu_acc_i),
    .data_gnt_i        (data_gnt_i),
    .data_rvalid_i     (data_rvalid_i),
    .data_err_i        (data_err_i),
    .data_req_o        (data_req_o),
    .addr_incr_req_o   (addr_incr_req_o),
    .second_part_o     (second_part),
    .ctrl_update_o     (ctrl_update),
    .ld_ctrl_o         (ld_ctrl),
    .rdata_update_o    (rdata_update),
    .lsu_req_done_o    (lsu_req_done_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .addr_last_o       (addr_last_o),
    .busy_o            (busy_o)
  );

  // bus request fields are combinational from the held core access
  lsu_wdata_align u_lsu_wdata_align (
    .lsu_acc_i     (lsu_acc_i),
    .second_part_i (second_part),
    .bus_req_o     (data_req_fields_o)
  );

  lsu_rdata_align u_lsu_rdata_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_update_i  (ctrl_update),
    .ld_ctrl_i      (ld_ctrl),
    .rdata_update_i (rdata_update),
    .data_rdata_i   (data_rdata_i),
    .lsu_rdata_o    (lsu_rdata_o)
  );

endmodule

`default_nettype wire

// ==== sim/lsu_sva.sv ====
// load/store unit bus assertions
// bound to the top level, watches the request and response ports
`default_nettype none

module lsu_sva import lsu_pkg::*; (
  input wire           clk_i,
  input wire           rst_ni,
  input wire           data_req_o,
  input wire bus_req_t data_req_fields_o,
  input wire           data_gnt_i,
  input wire           lsu_resp_valid_o,
  input wire           busy_o
);

  //////////////////////////////
  // request side
  //////////////////////////////

  // bus only sees word addresses
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> (data_req_fields_o.addr[1:0] == 2'b00))
    else $error("bus request address is not word aligned");

  // an ungranted request waits with its fields untouched
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (data_req_o && !data_gnt_i) |=> (data_req_o && $stable(data_req_fields_o)))
    else $error("ungranted bus request dropped or changed");

  //////////////////////////////
  // response side
  //////////////////////////////

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(lsu_resp_valid_o) |-> !busy_o)
    else $error("final response while the unit is busy");

endmodule

`default_nettype wire

// ==== sim/lsu_tb.sv ====
// load/store unit testbench
// random accesses from an LFSR, a byte memory behind the bus with random
// grant and response delays, and a reference model of the loaded values
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

  logic     clk_i = 1'b0;
  logic     rst_ni;
  logic     lsu_req_i;
  lsu_req_t lsu_acc_i;
  logic     lsu_req_done_o, lsu_resp_valid_o, lsu_rdata_valid_o;
  data_t    lsu_rdata_o;
  logic     addr_incr_req_o, load_err_o, store_err_o, busy_o;
  addr_t    addr_last_o;
  logic     data_req_o, data_gnt_i, data_rvalid_i, data_err_i;
  bus_req_t data_req_fields_o;
  data_t    data_rdata_i;

  logic [31:0] lfsr_q = 32'd96413;
  logic [7:0]  bus_mem [0:511];         // memory behind the bus
  logic [7:0]  ref_mem [0:511];         // reference copy
  int          cyc, gnt_cnt, acc_cycles;
  int          resp_due[$];
  data_t       resp_data[$];
  logic        resp_err[$];
  lsu_req_t    cur_acc;                 // access the core holds
  logic        core_active = 1'b0;
  int          n_gnts, n_resp, err_part, exp_gnts;
  logic        seen_rvalid, seen_lerr, seen_serr, check_busy = 1'b0;
  data_t       seen_rdata;
  addr_t       seen_addr_last;
  int          early_second, busy_checks, test_errors, total_errors, tests_run, accesses;

  always #4 clk_i = ~clk_i;

  lsu_top u_lsu_top (.*);

  bind lsu_top lsu_sva u_lsu_sva (
    .clk_i (clk_i), .rst_ni (rst_ni), .data_req_o (data_req_o),
    .data_req_fields_o (data_req_fields_o), .data_gnt_i (data_gnt_i),
    .lsu_resp_valid_o (lsu_resp_valid_o), .busy_o (busy_o)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  // galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic next_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) lfsr_q = lfsr_q ^ 32'h8020_0003;
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) r = {r[30:0], next_bit()};
    return r;
  endfunction

  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a * 29 + (a >> 5) * 7 + 8'h3c);  // every address bit counts
  endfunction

  function automatic int size_bytes(input lsu_size_e s);
    return (s == LSU_WORD) ? 4 : (s == LSU_HALF) ? 2 : 1;
  endfunction

  function automatic logic is_split(input lsu_req_t a);
    return ((a.size == LSU_WORD) && (a.addr[1:0] != 2'd0)) ||
           ((a.size == LSU_HALF) && (a.addr[1:0] == 2'd3));
  endfunction

  // little endian gather from the reference copy, then extension
  function automatic data_t model_load(input lsu_req_t a);
    data_t v;
    int    n;
    v = '0;
    n = size_bytes(a.size);
    for (int i = 0; i < n; i++) v[8*i +: 8] = ref_mem[(int'(a.addr[8:0]) + i) & 511];
    if (n == 2 && a.sign_ext && v[15]) v[31:16] = '1;
    if (n == 1 && a.sign_ext && v[7])  v[31:8]  = '1;
    return v;
  endfunction

  function automatic lsu_req_t make_acc(input logic we, input lsu_size_e sz,
                                        input int off, input logic sx);
    lsu_req_t    a;
    logic [6:0]  w;
    w = 7'(rand_bits(7));
    if (w == 7'd127) w = 7'd126;        // keep the second word inside memory
    a.we       = we;
    a.size     = sz;
    a.sign_ext = sx;
    a.addr     = {23'h000010, w, 2'(off)};
    a.wdata    = rand_bits(32);
    return a;
  endfunction

  // any size and offset, fields drawn in a fixed order
  function automatic lsu_req_t rand_acc(input logic we);
    lsu_size_e sz;
    int        off;
    logic      sx;
    sz  = lsu_size_e'(2'(rand_bits(2)));
    off = int'(rand_bits(2));
    sx  = next_bit();
    return make_acc(we, sz, off, sx);
  endfunction

  task automatic report_mismatch(input string msg);
    $display("MISMATCH @%0t: %s", $time, msg);
    test_errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    test_errors++;
  endtask

  task automatic end_test(input string name);
    $display("test %s done, %0d errors", name, test_errors);
    total_errors += test_errors;
    test_errors = 0;
    tests_run++;
  endtask

  //////////////////////////////
  // bus model, one cycle
  //////////////////////////////

  task automatic check_grant(input int part);
    addr_t   exp_addr;
    int      off, n, idx;
    logic [7:0] lane_byte;
    data_t   rd;
    off = cur_acc.addr[1:0];
    n = size_bytes(cur_acc.size);
    exp_addr = {cur_acc.addr[31:2], 2'b00} + 32'(4 * part);
    if (data_req_fields_o.addr != exp_addr || data_req_fields_o.we != cur_acc.we)
      report_mismatch($sformatf("part %0d addr %h we %b", part,
                      data_req_fields_o.addr, data_req_fields_o.we));
    for (int l = 0; l < 4; l++) begin
      idx = l + 4 * part;               // byte position counted from the first word
      lane_byte = cur_acc.wdata[8*((l - off) & 3) +: 8];
      if (data_req_fields_o.be[l] != (idx >= off && idx < off + n))
        report_mismatch($sformatf("part %0d be %b lane %0d", part, data_req_fields_o.be, l));
      else if (cur_acc.we && data_req_fields_o.be[l] &&
               data_req_fields_o.wdata[8*l +: 8] != lane_byte)
        report_mismatch($sformatf("store lane %0d got %h exp %h", l,
                        data_req_fields_o.wdata[8*l +: 8], lane_byte));
      if (cur_acc.we && data_req_fields_o.be[l])
        bus_mem[{data_req_fields_o.addr[8:2], 2'(l)}] = data_req_fields_o.wdata[8*l +: 8];
      rd[8*l +: 8] = bus_mem[{data_req_fields_o.addr[8:2], 2'(l)}];
    end
    resp_data.push_back(rd);
    resp_err.push_back(err_part == part + 1);
  endtask

  task automatic step();
    int due;
    @(negedge clk_i);
    lsu_req_i = core_active;
    lsu_acc_i = cur_acc;
    if (core_active && addr_incr_req_o) lsu_acc_i.addr = cur_acc.addr + 32'd4;
    data_gnt_i = (gnt_cnt == 0);
    if (resp_due.size() != 0 && resp_due[0] <= cyc) begin
      data_rvalid_i = 1'b1;
      data_rdata_i  = resp_data.pop_front();
      data_err_i    = resp_err.pop_front();
      void'(resp_due.pop_front());
    end else begin
      data_rvalid_i = 1'b0;
      data_err_i    = 1'b0;
      data_rdata_i  = '0;
    end
    #2;                                  // outputs settled, next edge is far
    // busy from the first held cycle until the last grant
    if (check_busy && core_active && acc_cycles > 0) begin
      busy_checks++;
      if (busy_o !== 1'b1) report_mismatch("busy_o low while request waits");
    end
    if (addr_incr_req_o !== (core_active && n_gnts == 1))
      report_mismatch($sformatf("addr_incr_req %b after %0d grants", addr_incr_req_o, n_gnts));
    if (data_req_o && data_gnt_i) begin
      if (n_gnts == 1 && resp_due.size() != 0) early_second++;
      check_grant(n_gnts);
      due = cyc + 1 + (rand_bits(2) % 3);
      if (resp_due.size() != 0 && due <= resp_due[$]) due = resp_due[$] + 1;
      resp_due.push_back(due);
      n_gnts++;
      gnt_cnt = rand_bits(2);
      if (lsu_req_done_o !== (n_gnts == exp_gnts))
        report_mismatch($sformatf("done strobe %b at grant %0d", lsu_req_done_o, n_gnts));
    end else begin
      if (data_req_o && gnt_cnt > 0) gnt_cnt--;
      if (lsu_req_done_o) report_mismatch("done strobe without grant");
    end
    if (lsu_req_done_o) core_active = 1'b0;
    if (lsu_resp_valid_o) begin
      n_resp++;
      seen_rvalid    = lsu_rdata_valid_o;
      seen_rdata     = lsu_rdata_o;
      seen_lerr      = load_err_o;
      seen_serr      = store_err_o;
      seen_addr_last = addr_last_o;
    end
    acc_cycles++;
    cyc++;
  endtask

  //////////////////////////////
  // one access, start to end
  //////////////////////////////

  task automatic run_access(input lsu_req_t acc, input int ep);
    int    guard;
    data_t exp;
    addr_t exp_last;
    cur_acc = acc;
    err_part = ep;
    exp_gnts = is_split(acc) ? 2 : 1;
    exp = model_load(acc);
    n_gnts = 0;
    n_resp = 0;
    acc_cycles = 0;
    {seen_rvalid, seen_lerr, seen_serr} = '0;
    core_active = 1'b1;
    guard = 0;
    while ((core_active || resp_due.size() != 0 || n_resp == 0) && guard < 60) begin
      step();
      guard++;
    end
    if (guard >= 60) begin
      report_failure($sformatf("timeout: access to %h never completed", acc.addr));
      core_active = 1'b0;
      resp_due.delete();
      resp_data.delete();
      resp_err.delete();
    end else begin
      step();                            // catch stray responses
      step();
      accesses++;
      if (ep == 1 || !is_split(acc)) exp_last = acc.addr;
      else exp_last = {acc.addr[31:2], 2'b00} + 32'd4;
      if (n_gnts != exp_gnts || n_resp != 1)
        report_mismatch($sformatf("%0d grants %0d responses for %h", n_gnts, n_resp, acc.addr));
      if (seen_addr_last != exp_last)
        report_mismatch($sformatf("addr_last %h exp %h", seen_addr_last, exp_last));
      if (ep != 0) begin
        if (seen_lerr != !acc.we || seen_serr != acc.we || seen_rvalid)
          report_mismatch($sformatf("error strobes l%b s%b v%b", seen_lerr, seen_serr,
                          seen_rvalid));
      end else if (seen_lerr || seen_serr) begin
        report_mismatch("error strobe without injected error");
      end else if (!acc.we && (!seen_rvalid || seen_rdata != exp)) begin
        report_mismatch($sformatf("load %h got %h exp %h", acc.addr, seen_rdata, exp));
      end
      if (acc.we) begin
        for (int i = 0; i < size_bytes(acc.size); i++)
          ref_mem[(int'(acc.addr[8:0]) + i) & 511] = acc.wdata[8*i +: 8];
      end
      if (check_busy && busy_o !== 1'b0) report_mismatch("busy_o high after last grant");
    end
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  initial begin
    lsu_req_t  a, rb;
    lsu_size_e sz;
    int        off, ep;
    logic      we_b, sx_b;
    rst_ni        = 1'b0;
    lsu_req_i     = 1'b0;
    lsu_acc_i     = '0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_err_i    = 1'b0;
    data_rdata_i  = '0;
    cur_acc       = '0;
    for (int i = 0; i < 512; i++) begin
      bus_mem[i] = fill_byte(i);
      ref_mem[i] = fill_byte(i);
    end
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;

    // reset values, then busy across held and split requests
    #2;
    if ({data_req_o, addr_incr_req_o, lsu_req_done_o, lsu_resp_valid_o,
         lsu_rdata_valid_o, load_err_o, store_err_o, busy_o} !== 8'h00)
      report_mismatch("control output not low after reset");
    if (addr_last_o !== '0)
      report_mismatch($sformatf("addr_last %h after reset", addr_last_o));
    check_busy = 1'b1;
    for (int k = 0; k < 16; k++) begin
      we_b = next_bit();
      run_access(rand_acc(we_b), 0);
    end
    if (busy_checks == 0) report_failure("busy_o was never checked, no grant was held back");
    end_test("reset_busy");

    // aligned loads, all sizes, offsets and extensions
    for (int r = 0; r < 3; r++)
      for (int s = 0; s < 4; s++)
        for (int o = 0; o < 4; o++)
          for (int x = 0; x < 2; x++) begin
            a = make_acc(1'b0, lsu_size_e'(2'(s)), o, 1'(x));
            if (!is_split(a)) run_access(a, 0);
          end
    end_test("aligned_load");

    // stores, then read back the touched words
    for (int s = 0; s < 4; s++)
      for (int o = 0; o < 4; o++) begin
        a = make_acc(1'b1, lsu_size_e'(2'(s)), o, 1'b0);
        run_access(a, 0);
        rb          = a;
        rb.we       = 1'b0;
        rb.size     = LSU_WORD;
        rb.sign_ext = 1'b0;
        rb.addr     = {a.addr[31:2], 2'b00};
        run_access(rb, 0);
        if (is_split(a)) begin
          rb.addr = rb.addr + 32'd4;
          run_access(rb, 0);
        end
      end
    end_test("store");

    // misaligned words and crossing halfwords
    for (int k = 0; k < 48; k++) begin
      sz   = next_bit() ? LSU_WORD : LSU_HALF;
      off  = (sz == LSU_HALF) ? 3 : 1 + int'(rand_bits(2) % 3);
      we_b = next_bit();
      sx_b = next_bit();
      a    = make_acc(we_b, sz, off, sx_b);
      run_access(a, 0);
    end
    if (early_second == 0)
      report_failure("no second grant came before the first response");
    end_test("split");

    // bus errors on either part
    for (int k = 0; k < 48; k++) begin
      we_b = next_bit();
      a    = rand_acc(we_b);
      ep   = is_split(a) ? 1 + int'(next_bit()) : 1;
      run_access(a, ep);
    end
    end_test("bus_error");

    $display("%0d tests, %0d accesses, %0d busy checks, %0d early second grants, %0d errors",
             tests_run, accesses, busy_checks, early_second, total_errors);
    if (total_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/lsu_pkg.sv
hdl/lsu_ctrl.sv
hdl/lsu_wdata_align.sv
hdl/lsu_rdata_align.sv
hdl/lsu_top.sv
sim/lsu_sva.sv
sim/lsu_tb.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - hdl/lsu_pkg.sv
  - hdl/lsu_ctrl.sv
  - hdl/lsu_wdata_align.sv
  - hdl/lsu_rdata_align.sv
  - hdl/lsu_top.sv
  - target: simulation
    files:
      - sim/lsu_sva.sv
      - sim/lsu_tb.sv
